/* rtl/riscv_config.svh */
// build-time constants for the multicycle RV32I core
// data width, reset PC, register count and base opcode values
`ifndef RISCV_CONFIG_SVH
`define RISCV_CONFIG_SVH
`define RV_XLEN        32
`define RV_START_ADDR  32'h0000_0000
`define RV_NREGS       32
`define RV_OP_LUI      7'b0110111
`define RV_OP_AUIPC    7'b0010111
`define RV_OP_JAL      7'b1101111
`define RV_OP_JALR     7'b1100111
`define RV_OP_BR       7'b1100011
`define RV_OP_LOAD     7'b0000011
`define RV_OP_STORE    7'b0100011
`define RV_OP_IMM      7'b0010011
`define RV_OP_REG      7'b0110011
`endif

/* rtl/riscv_pkg.sv */
// shared types of the multicycle core
// word and index types, ALU function codes, phase and select enums
`default_nettype none
`include "riscv_config.svh"

package riscv_pkg;
	typedef logic [`RV_XLEN-1:0] word_t;
	typedef logic [$clog2(`RV_NREGS)-1:0] reg_idx_t;

	// {sub or arithmetic shift, funct3}
	typedef logic [3:0] alu_fn_t;
	localparam alu_fn_t ALU_ADD = 4'b0000;
	localparam alu_fn_t ALU_SUB = 4'b1000;

	typedef enum logic [3:0] {
		CL_LUI, CL_AUIPC, CL_JAL, CL_JALR, CL_BRANCH,
		CL_LOAD, CL_STORE, CL_ALU, CL_NOP
	} instr_class_t;

	typedef enum logic [2:0] {
		PH_IF, PH_ID, PH_EX, PH_MEM, PH_EXU, PH_MEMU, PH_WB, PH_MEM_WAIT
	} phase_t;

	typedef enum logic [1:0] {PC_PLUS4, PC_BRANCH, PC_JAL, PC_JALR} pc_sel_t;
	typedef enum logic [1:0] {RS_ALU, RS_IMM, RS_PC, RS_LOAD} reg_src_t;
	// merged word for SB/SH, or the held word while waiting
	typedef enum logic [1:0] {MS_RS2, MS_MERGE, MS_HOLD} mem_src_t;
	typedef enum logic [1:0] {AS_PC, AS_ALU, AS_MAR} addr_sel_t;
endpackage

`default_nettype wire

/* rtl/alu.sv */
// combinational ALU
// add, sub, shifts, signed and unsigned compare, logic operations
`timescale 1ns/100ps
`default_nettype none

module alu (
	input  wire riscv_pkg::alu_fn_t  fn,
	input  wire riscv_pkg::word_t    op_a,
	input  wire riscv_pkg::word_t    op_b,
	output riscv_pkg::word_t         y
);
	logic [4:0] shamt;

	assign shamt = op_b[4:0];

	always_comb begin
		case (fn[2:0])
			3'b000: y = fn[3] ? op_a - op_b : op_a + op_b;
			3'b001: y = op_a << shamt;
			3'b010: y = {31'b0, $signed(op_a) < $signed(op_b)};
			3'b011: y = {31'b0, op_a < op_b};
			3'b100: y = op_a ^ op_b;
			3'b101: begin
				if (fn[3])
					y = $signed(op_a) >>> shamt;
				else
					y = op_a >> shamt;
			end
			3'b110: y = op_a | op_b;
			default: y = op_a & op_b;
		endcase
	end
endmodule

`default_nettype wire

/* rtl/register_file.sv */
// integer register file
// two asynchronous read ports, one synchronous write port, x0 reads zero
`timescale 1ns/100ps
`default_nettype none
`include "riscv_config.svh"

module register_file (
	input  wire                        clk,
	input  wire riscv_pkg::reg_idx_t   ra0,
	input  wire riscv_pkg::reg_idx_t   ra1,
	input  wire riscv_pkg::reg_idx_t   wa,
	input  wire                        we,
	input  wire riscv_pkg::word_t      wd,
	output riscv_pkg::word_t           rd0,
	output riscv_pkg::word_t           rd1
);
	riscv_pkg::word_t regs [`RV_NREGS];

	assign rd0 = (ra0 == '0) ? '0 : regs[ra0];
	assign rd1 = (ra1 == '0) ? '0 : regs[ra1];

	always_ff @(posedge clk) begin
		if (we && wa != '0)
			regs[wa] <= wd;
	end
endmodule

`default_nettype wire

/* rtl/instr_decoder.sv */
// instruction decoder
// class, immediate and EX-phase ALU function of the latched instruction
`timescale 1ns/100ps
`default_nettype none
`include "riscv_config.svh"

module instr_decoder (
	input  wire riscv_pkg::word_t       instr,
	output riscv_pkg::instr_class_t     cls,
	output riscv_pkg::word_t            imm,
	output riscv_pkg::alu_fn_t          ex_fn,
	output logic                        store_sub,
	output logic                        br_taken_if_zero
);
	logic [6:0] opcode;
	logic [2:0] funct3;
	riscv_pkg::word_t imm_i, imm_s, imm_b, imm_u, imm_j;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];

	assign imm_i = {{21{instr[31]}}, instr[30:20]};
	assign imm_s = {{21{instr[31]}}, instr[30:25], instr[11:7]};
	assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

	// FENCE, SYSTEM and unknown opcodes fall to CL_NOP
	always_comb begin
		case (opcode)
			`RV_OP_LUI:              cls = riscv_pkg::CL_LUI;
			`RV_OP_AUIPC:            cls = riscv_pkg::CL_AUIPC;
			`RV_OP_JAL:              cls = riscv_pkg::CL_JAL;
			`RV_OP_JALR:             cls = riscv_pkg::CL_JALR;
			`RV_OP_BR:               cls = riscv_pkg::CL_BRANCH;
			`RV_OP_LOAD:             cls = riscv_pkg::CL_LOAD;
			`RV_OP_STORE:            cls = riscv_pkg::CL_STORE;
			`RV_OP_IMM, `RV_OP_REG:  cls = riscv_pkg::CL_ALU;
			default:                 cls = riscv_pkg::CL_NOP;
		endcase
	end

	always_comb begin
		case (cls)
			riscv_pkg::CL_LUI, riscv_pkg::CL_AUIPC: imm = imm_u;
			riscv_pkg::CL_JAL:                      imm = imm_j;
			riscv_pkg::CL_BRANCH:                   imm = imm_b;
			riscv_pkg::CL_STORE:                    imm = imm_s;
			riscv_pkg::CL_NOP:                      imm = '0;
			default:                                imm = imm_i;
		endcase
	end

	always_comb begin
		ex_fn = riscv_pkg::ALU_ADD;
		if (cls == riscv_pkg::CL_ALU) begin
			if (opcode == `RV_OP_REG)
				ex_fn = {instr[30], funct3};
			else
				ex_fn = {(funct3 == 3'b101) && instr[30], funct3};
		end else if (cls == riscv_pkg::CL_BRANCH) begin
			// BEQ/BNE subtract, the rest use slt or sltu
			ex_fn = funct3[2] ? {2'b00, 1'b1, funct3[1]} : riscv_pkg::ALU_SUB;
		end
	end

	assign store_sub = (cls == riscv_pkg::CL_STORE) && !funct3[1];
	// BEQ, BGE, BGEU taken on a zero compare result
	assign br_taken_if_zero = funct3[2] ? funct3[0] : !funct3[0];
endmodule

`default_nettype wire

/* rtl/control_fsm.sv */
// control FSM of the multicycle core
// phase and return-phase registers, next phase and datapath strobes
`timescale 1ns/100ps
`default_nettype none

module control_fsm (
	input  wire                           clk,
	input  wire                           rst,
	input  wire riscv_pkg::instr_class_t  cls,
	input  wire                           store_sub,
	input  wire                           br_taken_if_zero,
	input  wire                           alu_nonzero,
	input  wire                           ready,
	output logic                          rd,
	output logic                          we,
	output logic                          pc_we,
	output riscv_pkg::pc_sel_t            pc_sel,
	output logic                          ir_we,
	output riscv_pkg::addr_sel_t          addr_sel,
	output riscv_pkg::mem_src_t           mem_src,
	output logic                          reg_we,
	output riscv_pkg::reg_src_t           reg_src,
	output logic                          alu_src_a,
	output logic                          alu_src_b,
	output logic                          alu_sel_ex
);
	riscv_pkg::phase_t phase, phase_n;
	riscv_pkg::phase_t ret, ret_n;
	logic ret_set;

	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= riscv_pkg::PH_IF;
			ret <= riscv_pkg::PH_IF;
		end else begin
			phase <= phase_n;
			if (ret_set)
				ret <= ret_n;
		end
	end

	always_comb begin
		phase_n = phase;
		ret_n = riscv_pkg::PH_IF;
		ret_set = 1'b0;
		rd = 1'b0;
		we = 1'b0;
		pc_we = 1'b0;
		pc_sel = riscv_pkg::PC_PLUS4;
		ir_we = 1'b0;
		addr_sel = riscv_pkg::AS_PC;
		mem_src = riscv_pkg::MS_RS2;
		reg_we = 1'b0;
		reg_src = riscv_pkg::RS_ALU;
		alu_src_a = 1'b0;
		alu_src_b = 1'b0;
		alu_sel_ex = 1'b0;
		case (phase)
			riscv_pkg::PH_IF: begin
				rd = 1'b1;
				ir_we = ready;
				ret_n = riscv_pkg::PH_ID;
				ret_set = 1'b1;
				phase_n = ready ? riscv_pkg::PH_ID : riscv_pkg::PH_MEM_WAIT;
			end
			riscv_pkg::PH_ID: begin
				// pc += 4 while the ALU forms pc + imm
				pc_we = 1'b1;
				alu_src_a = 1'b1;
				alu_src_b = 1'b1;
				case (cls)
					riscv_pkg::CL_NOP: phase_n = riscv_pkg::PH_IF;
					riscv_pkg::CL_LUI, riscv_pkg::CL_AUIPC, riscv_pkg::CL_JAL:
						phase_n = riscv_pkg::PH_WB;
					default: phase_n = riscv_pkg::PH_EX;
				endcase
			end
			riscv_pkg::PH_EX: begin
				alu_sel_ex = 1'b1;
				alu_src_b = (cls != riscv_pkg::CL_BRANCH);
				if (cls == riscv_pkg::CL_LOAD || cls == riscv_pkg::CL_STORE)
					phase_n = riscv_pkg::PH_MEM;
				else
					phase_n = riscv_pkg::PH_WB;
			end
			riscv_pkg::PH_MEM: begin
				addr_sel = riscv_pkg::AS_ALU;
				// SB and SH read the word first
				if (cls == riscv_pkg::CL_LOAD || store_sub)
					rd = 1'b1;
				else
					we = 1'b1;
				if (cls == riscv_pkg::CL_LOAD)
					ret_n = riscv_pkg::PH_WB;
				else if (store_sub)
					ret_n = riscv_pkg::PH_EXU;
				ret_set = 1'b1;
				phase_n = ready ? ret_n : riscv_pkg::PH_MEM_WAIT;
			end
			riscv_pkg::PH_EXU: begin
				// lane merge into mwr, address recomputed
				addr_sel = riscv_pkg::AS_MAR;
				mem_src = riscv_pkg::MS_MERGE;
				alu_src_b = 1'b1;
				phase_n = riscv_pkg::PH_MEMU;
			end
			riscv_pkg::PH_MEMU: begin
				we = 1'b1;
				addr_sel = riscv_pkg::AS_ALU;
				mem_src = riscv_pkg::MS_HOLD;
				ret_set = 1'b1;
				phase_n = ready ? riscv_pkg::PH_IF : riscv_pkg::PH_MEM_WAIT;
			end
			riscv_pkg::PH_WB: begin
				phase_n = riscv_pkg::PH_IF;
				case (cls)
					riscv_pkg::CL_ALU, riscv_pkg::CL_AUIPC: reg_we = 1'b1;
					riscv_pkg::CL_LUI: begin
						reg_we = 1'b1;
						reg_src = riscv_pkg::RS_IMM;
					end
					riscv_pkg::CL_JAL, riscv_pkg::CL_JALR: begin
						reg_we = 1'b1;
						reg_src = riscv_pkg::RS_PC;
						pc_we = 1'b1;
						pc_sel = (cls == riscv_pkg::CL_JAL) ? riscv_pkg::PC_JAL
							: riscv_pkg::PC_JALR;
					end
					riscv_pkg::CL_BRANCH: begin
						pc_we = br_taken_if_zero ^ alu_nonzero;
						pc_sel = riscv_pkg::PC_BRANCH;
					end
					riscv_pkg::CL_LOAD: begin
						reg_we = 1'b1;
						reg_src = riscv_pkg::RS_LOAD;
					end
					default: ;
				endcase
			end
			riscv_pkg::PH_MEM_WAIT: begin
				addr_sel = riscv_pkg::AS_MAR;
				mem_src = riscv_pkg::MS_HOLD;
				ir_we = ready && (ret == riscv_pkg::PH_ID);
				if (ready)
					phase_n = ret;
			end
			default: phase_n = riscv_pkg::PH_IF;
		endcase
	end
endmodule

`default_nettype wire

/* rtl/datapath.sv */
// datapath of the multicycle core
// PC, IR, operand and memory registers, muxes, load extraction, lane merge
`timescale 1ns/100ps
`default_nettype none
`include "riscv_config.svh"

module datapath (
	input  wire                         clk,
	input  wire                         rst,
	input  wire                         pc_we,
	input  wire riscv_pkg::pc_sel_t     pc_sel,
	input  wire                         ir_we,
	input  wire riscv_pkg::addr_sel_t   addr_sel,
	input  wire riscv_pkg::mem_src_t    mem_src,
	input  wire                         reg_we,
	input  wire riscv_pkg::reg_src_t    reg_src,
	input  wire                         alu_src_a,
	input  wire                         alu_src_b,
	input  wire                         alu_sel_ex,
	input  wire riscv_pkg::word_t       imm,
	input  wire riscv_pkg::alu_fn_t     ex_fn,
	input  wire riscv_pkg::word_t       spo,
	output riscv_pkg::word_t            instr,
	output riscv_pkg::word_t            a,
	output riscv_pkg::word_t            d,
	output logic                        alu_nonzero
);
	riscv_pkg::word_t pc, next_pc;
	riscv_pkg::word_t rs1_q, rs2_q, alu_out, alu_out2;
	riscv_pkg::word_t mar, mwr, mdr;
	riscv_pkg::word_t rs1_val, rs2_val, op_a, op_b, alu_y;
	riscv_pkg::word_t mem_addr, wdata, load_val, wb_data, store_merge;
	riscv_pkg::alu_fn_t fn;
	logic [7:0] ld_byte;
	logic [15:0] ld_half;
	logic reg_form;

	register_file u_rf (
		.clk(clk), .ra0(instr[19:15]), .ra1(instr[24:20]), .wa(instr[11:7]),
		.we(reg_we), .wd(wb_data), .rd0(rs1_val), .rd1(rs2_val)
	);

	// OP keeps rs2 in EX, opcode bits 5:4 are both set only there
	assign reg_form = alu_sel_ex && instr[5] && instr[4];
	assign op_a = alu_src_a ? pc : rs1_q;
	assign op_b = (alu_src_b && !reg_form) ? imm : rs2_q;
	assign fn = alu_sel_ex ? ex_fn : riscv_pkg::ALU_ADD;

	alu u_alu (.fn(fn), .op_a(op_a), .op_b(op_b), .y(alu_y));

	always_ff @(posedge clk) begin
		if (rst)
			pc <= `RV_START_ADDR;
		else if (pc_we)
			pc <= next_pc;
	end

	always_ff @(posedge clk) begin
		rs1_q <= rs1_val;
		rs2_q <= rs2_val;
		alu_out <= alu_y;
		alu_out2 <= alu_out;
		mar <= mem_addr;
		mwr <= wdata;
		mdr <= spo;
		if (ir_we)
			instr <= spo;
	end

	always_comb begin
		case (addr_sel)
			riscv_pkg::AS_ALU: mem_addr = alu_out;
			riscv_pkg::AS_MAR: mem_addr = mar;
			default:           mem_addr = pc;
		endcase
		case (pc_sel)
			riscv_pkg::PC_BRANCH: next_pc = alu_out2;
			riscv_pkg::PC_JAL:    next_pc = alu_out;
			riscv_pkg::PC_JALR:   next_pc = {alu_out[`RV_XLEN-1:1], 1'b0};
			default:              next_pc = pc + 32'd4;
		endcase
	end

	// little-endian lanes picked by the byte offset in mar
	always_comb begin
		ld_byte = mdr[{mar[1:0], 3'b000} +: 8];
		ld_half = mdr[{mar[1], 4'b0000} +: 16];
		case (instr[13:12])
			2'b00:   load_val = instr[14] ? {24'b0, ld_byte} : {{24{ld_byte[7]}}, ld_byte};
			2'b01:   load_val = instr[14] ? {16'b0, ld_half} : {{16{ld_half[15]}}, ld_half};
			default: load_val = mdr;
		endcase
		store_merge = mdr;
		if (instr[12])
			store_merge[{mar[1], 4'b0000} +: 16] = rs2_q[15:0];
		else
			store_merge[{mar[1:0], 3'b000} +: 8] = rs2_q[7:0];
	end

	always_comb begin
		case (mem_src)
			riscv_pkg::MS_MERGE: wdata = store_merge;
			riscv_pkg::MS_HOLD:  wdata = mwr;
			default:             wdata = rs2_val;
		endcase
		case (reg_src)
			riscv_pkg::RS_IMM:  wb_data = imm;
			riscv_pkg::RS_PC:   wb_data = pc;
			riscv_pkg::RS_LOAD: wb_data = load_val;
			default:            wb_data = alu_out;
		endcase
	end

	assign a = {mem_addr[`RV_XLEN-1:2], 2'b00};
	assign d = wdata;
	assign alu_nonzero = |alu_out;
endmodule

`default_nettype wire

/* rtl/riscv_multicyc.sv */
// multicycle RV32I core top level
// decoder, control FSM and datapath on one shared memory port
`timescale 1ns/100ps
`default_nettype none

module riscv_multicyc (
	input  wire                     clk,
	input  wire                     rst,
	output riscv_pkg::word_t        a,
	output riscv_pkg::word_t        d,
	output logic                    we,
	output logic                    rd,
	input  wire riscv_pkg::word_t   spo,
	input  wire                     ready
);
	wire riscv_pkg::word_t instr;
	wire riscv_pkg::word_t imm;
	wire riscv_pkg::alu_fn_t ex_fn;
	wire riscv_pkg::instr_class_t cls;
	wire store_sub;
	wire br_taken_if_zero;
	wire alu_nonzero;
	wire pc_we;
	wire riscv_pkg::pc_sel_t pc_sel;
	wire ir_we;
	wire riscv_pkg::addr_sel_t addr_sel;
	wire riscv_pkg::mem_src_t mem_src;
	wire reg_we;
	wire riscv_pkg::reg_src_t reg_src;
	wire alu_src_a;
	wire alu_src_b;
	wire alu_sel_ex;

	instr_decoder u_decoder (
		.instr(instr), .cls(cls), .imm(imm), .ex_fn(ex_fn),
		.store_sub(store_sub), .br_taken_if_zero(br_taken_if_zero)
	);

	control_fsm u_ctrl (
		.clk(clk), .rst(rst), .cls(cls), .store_sub(store_sub),
		.br_taken_if_zero(br_taken_if_zero), .alu_nonzero(alu_nonzero), .ready(ready),
		.rd(rd), .we(we), .pc_we(pc_we), .pc_sel(pc_sel), .ir_we(ir_we),
		.addr_sel(addr_sel), .mem_src(mem_src), .reg_we(reg_we), .reg_src(reg_src),
		.alu_src_a(alu_src_a), .alu_src_b(alu_src_b), .alu_sel_ex(alu_sel_ex)
	);

	datapath u_dp (
		.clk(clk), .rst(rst), .pc_we(pc_we), .pc_sel(pc_sel), .ir_we(ir_we),
		.addr_sel(addr_sel), .mem_src(mem_src), .reg_we(reg_we), .reg_src(reg_src),
		.alu_src_a(alu_src_a), .alu_src_b(alu_src_b), .alu_sel_ex(alu_sel_ex),
		.imm(imm), .ex_fn(ex_fn), .spo(spo), .instr(instr), .a(a), .d(d),
		.alu_nonzero(alu_nonzero)
	);
endmodule

`default_nettype wire

/* verif/riscv_multicyc_sva.sv */
// memory port assertions for the multicycle core
// strobe exclusion, word alignment, request stability, quiet we after reset
`timescale 1ns/100ps
`default_nettype none

module riscv_multicyc_sva (
	input wire                    clk,
	input wire                    rst,
	input wire riscv_pkg::word_t  a,
	input wire riscv_pkg::word_t  d,
	input wire                    we,
	input wire                    rd,
	input wire                    ready
);
	logic pend;
	logic pend_we;
	riscv_pkg::word_t held_a;
	riscv_pkg::word_t held_d;
	int sva_errors = 0;

	// request still waiting for ready, with the values seen at its strobe
	always_ff @(posedge clk) begin
		if (rst) begin
			pend <= 1'b0;
			pend_we <= 1'b0;
		end else if ((rd || we) && !ready) begin
			pend <= 1'b1;
			pend_we <= we;
			held_a <= a;
			held_d <= d;
		end else if (ready) begin
			pend <= 1'b0;
		end
	end

	assert property (@(posedge clk) disable iff (rst) !(rd && we))
	else begin
		$error("rd and we strobed in the same cycle");
		sva_errors++;
	end

	assert property (@(posedge clk) disable iff (rst) (rd || we) |-> (a[1:0] == 2'b00))
	else begin
		$error("memory address not word aligned");
		sva_errors++;
	end

	assert property (@(posedge clk) disable iff (rst)
		pend |-> (a == held_a && (!pend_we || d == held_d) && !rd && !we))
	else begin
		$error("request changed or new strobe before ready");
		sva_errors++;
	end

	assert property (@(posedge clk) $fell(rst) |-> !we)
	else begin
		$error("we high in the first cycle after reset");
		sva_errors++;
	end
endmodule

`default_nettype wire

/* verif/tb_riscv_multicyc.sv */
// testbench for the multicycle RV32I core
// clock and reset, memory model with random latency, store checking
`timescale 1ns/100ps
`default_nettype none

module tb_riscv_multicyc;
	localparam int RST_CYCLES = 5;
	// about 75 instructions at worst-case latency stay far below this
	localparam int MAX_CYCLES = 4000;
	localparam int MEM_WORDS = 1024;
	localparam int MAX_STORES = 64;

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic ready = 1'b0;
	riscv_pkg::word_t spo = '0;
	logic we;
	logic rd;
	riscv_pkg::word_t a;
	riscv_pkg::word_t d;

	riscv_pkg::word_t mem [MEM_WORDS];
	riscv_pkg::word_t exp_addr [MAX_STORES];
	riscv_pkg::word_t exp_data [MAX_STORES];
	int exp_count = 0;
	int store_idx = 0;
	int errors = 0;
	int cycles = 0;
	int neg_count = 0;
	int wait_left = 0;
	logic busy = 1'b0;
	logic pend_write = 1'b0;
	logic done = 1'b0;

	riscv_multicyc uut (
		.clk(clk), .rst(rst), .a(a), .d(d), .we(we), .rd(rd),
		.spo(spo), .ready(ready)
	);

	bind riscv_multicyc riscv_multicyc_sva u_sva (
		.clk(clk), .rst(rst), .a(a), .d(d), .we(we), .rd(rd), .ready(ready)
	);

	initial begin
		forever #2 clk = ~clk;
	end

	task automatic fill_memory;
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = 32'h5A00_0000 ^ (i * 32'h0001_0103);
	endtask

	// P lines preload memory, S lines list the expected stores in order
	task automatic load_vectors;
		int fd;
		int n;
		string line;
		logic [7:0] tag;
		riscv_pkg::word_t addr;
		riscv_pkg::word_t data;
		fd = $fopen("verif/core_vectors.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("cannot open the vector file");
			return;
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n > 0)
				n = $sscanf(line, "%s %h %h", tag, addr, data);
			if (n == 3 && tag == "P") begin
				mem[addr[11:2]] = data;
			end else if (n == 3 && tag == "S" && exp_count < MAX_STORES) begin
				exp_addr[exp_count] = addr;
				exp_data[exp_count] = data;
				exp_count++;
			end
		end
		$fclose(fd);
	endtask

	task automatic check_store(input riscv_pkg::word_t addr, input riscv_pkg::word_t data);
		if (store_idx >= exp_count) begin
			errors++;
			$display("store to %h beyond the end of the expected list", addr);
		end else begin
			if (addr !== exp_addr[store_idx]) begin
				errors++;
				$display("FAIL a: expected %h, got %h at store %0d",
					exp_addr[store_idx], addr, store_idx);
			end
			if (data !== exp_data[store_idx]) begin
				errors++;
				$display("FAIL d: expected %h, got %h at store %0d",
					exp_data[store_idx], data, store_idx);
			end
			store_idx++;
			if (store_idx == exp_count)
				done = 1'b1;
		end
	endtask

	task automatic serve_request;
		ready = 1'b1;
		if (pend_write) begin
			mem[a[11:2]] = d;
			check_store(a, d);
		end else begin
			spo = mem[a[11:2]];
		end
	endtask

	// reset release and memory responses on the falling edge
	always @(negedge clk) begin
		if (neg_count < RST_CYCLES)
			neg_count++;
		if (neg_count >= RST_CYCLES)
			rst = 1'b0;
		ready = 1'b0;
		if (!rst && !done) begin
			if (!busy && (rd || we)) begin
				busy = 1'b1;
				pend_write = we;
				wait_left = $urandom % 4;
			end
			if (busy) begin
				if (wait_left == 0) begin
					serve_request();
					busy = 1'b0;
				end else begin
					wait_left--;
				end
			end
		end
	end

	initial begin
		void'($urandom(32'h8221));
		fill_memory();
		load_vectors();
		if (exp_count == 0) begin
			errors++;
			$display("no expected stores found in the vector file");
		end
		while (!done && exp_count > 0 && cycles < MAX_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		if (!done && exp_count > 0) begin
			errors++;
			$display("timeout after %0d cycles with %0d of %0d expected stores seen",
				cycles, store_idx, exp_count);
		end
		errors += uut.u_sva.sva_errors;
		$display("errors: %0d, stores checked: %0d of %0d, cycles: %0d",
			errors, store_idx, exp_count, cycles);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end
endmodule

`default_nettype wire

/* riscv_multicyc.f */
+incdir+rtl
rtl/riscv_pkg.sv
rtl/alu.sv
rtl/register_file.sv
rtl/instr_decoder.sv
rtl/control_fsm.sv
rtl/datapath.sv
rtl/riscv_multicyc.sv
verif/riscv_multicyc_sva.sv
verif/tb_riscv_multicyc.sv

/* run_sim.sh */
#!/bin/sh
# build the core testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
	--top-module tb_riscv_multicyc -f riscv_multicyc.f \
	--Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_tb +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "sim passed" sim.log; then
	exit 0
fi
exit 1

/* verif/core_vectors.txt */
# P <word address> <instruction or data word>: memory image
# S <address> <data>: expected bus writes in order, last one finishes the run
P 00000000 40000513 addi x10,x0,0x400
P 00000004 60000593 addi x11,x0,0x600
P 00000008 FF900093 addi x1,x0,-7
P 0000000C 00500113 addi x2,x0,5
P 00000010 002081B3 add x3,x1,x2
P 00000014 00352023 sw x3
P 00000018 40110233 sub x4,x2,x1
P 0000001C 00452023 sw x4
P 00000020 4020D2B3 sra x5,x1,x2
P 00000024 00552023 sw x5
P 00000028 4010D313 srai x6,x1,1
P 0000002C 00652023 sw x6
P 00000030 01C0D393 srli x7,x1,28
P 00000034 00752023 sw x7
P 00000038 0020A433 slt x8,x1,x2
P 0000003C 0020B4B3 sltu x9,x1,x2
P 00000040 00852023 sw x8
P 00000044 00952023 sw x9
P 00000048 0F00C693 xori x13,x1,0xf0
P 0000004C 00D52023 sw x13
P 00000050 12345737 lui x14,0x12345
P 00000054 00E52023 sw x14
P 00000058 00001797 auipc x15,1
P 0000005C 00F52023 sw x15
P 00000060 0080086F jal x16,+8
P 00000064 00152023 sw x1 skipped
P 00000068 01052023 sw x16
P 0000006C 010808E7 jalr x17,16(x16)
P 00000070 00152023 sw x1 skipped
P 00000074 01152023 sw x17
P 00000078 00108463 beq x1,x1 taken
P 0000007C 00152023 sw x1 skipped
P 00000080 00208463 beq x1,x2 not taken
P 00000084 00252023 sw x2
P 00000088 00209463 bne x1,x2 taken
P 0000008C 00152023 sw x1 skipped
P 00000090 00109463 bne x1,x1 not taken
P 00000094 00252023 sw x2
P 00000098 0020C463 blt x1,x2 taken
P 0000009C 00152023 sw x1 skipped
P 000000A0 00114463 blt x2,x1 not taken
P 000000A4 00252023 sw x2
P 000000A8 00115463 bge x2,x1 taken
P 000000AC 00152023 sw x1 skipped
P 000000B0 0020D463 bge x1,x2 not taken
P 000000B4 00252023 sw x2
P 000000B8 00116463 bltu x2,x1 taken
P 000000BC 00152023 sw x1 skipped
P 000000C0 0020E463 bltu x1,x2 not taken
P 000000C4 00252023 sw x2
P 000000C8 0020F463 bgeu x1,x2 taken
P 000000CC 00152023 sw x1 skipped
P 000000D0 00117463 bgeu x2,x1 not taken
P 000000D4 00252023 sw x2
P 000000D8 00058903 lb x18,0(x11)
P 000000DC 01252023 sw x18
P 000000E0 00158903 lb x18,1(x11)
P 000000E4 01252023 sw x18
P 000000E8 0035C903 lbu x18,3(x11)
P 000000EC 01252023 sw x18
P 000000F0 00358903 lb x18,3(x11)
P 000000F4 01252023 sw x18
P 000000F8 0025C903 lbu x18,2(x11)
P 000000FC 01252023 sw x18
P 00000100 00259903 lh x18,2(x11)
P 00000104 01252023 sw x18
P 00000108 0025D903 lhu x18,2(x11)
P 0000010C 01252023 sw x18
P 00000110 00059903 lh x18,0(x11)
P 00000114 01252023 sw x18
P 00000118 00D580A3 sb x13,1(x11)
P 0000011C 00D58123 sb x13,2(x11)
P 00000120 00D581A3 sb x13,3(x11)
P 00000124 00D58023 sb x13,0(x11)
P 00000128 00D59123 sh x13,2(x11)
P 0000012C 00D59023 sh x13,0(x11)
P 00000130 0005A903 lw x18,0(x11)
P 00000134 01252023 sw x18
P 00000138 0000000F fence
P 0000013C 00001637 lui x12,1
P 00000140 FE462E23 sw x4,-4(x12)
P 00000144 0000006F jal x0,0
P 00000600 C5317F82 load and store data word
S 00000400 FFFFFFFE add
S 00000400 0000000C sub
S 00000400 FFFFFFFF sra
S 00000400 FFFFFFFC srai
S 00000400 0000000F srli
S 00000400 00000001 slt
S 00000400 00000000 sltu
S 00000400 FFFFFF09 xori
S 00000400 12345000 lui
S 00000400 00001058 auipc
S 00000400 00000064 jal link
S 00000400 00000070 jalr link
S 00000400 00000005 beq fall through
S 00000400 00000005 bne fall through
S 00000400 00000005 blt fall through
S 00000400 00000005 bge fall through
S 00000400 00000005 bltu fall through
S 00000400 00000005 bgeu fall through
S 00000400 FFFFFF82 lb 0
S 00000400 0000007F lb 1
S 00000400 000000C5 lbu 3
S 00000400 FFFFFFC5 lb 3
S 00000400 00000031 lbu 2
S 00000400 FFFFC531 lh 2
S 00000400 0000C531 lhu 2
S 00000400 00007F82 lh 0
S 00000600 C5310982 sb 1
S 00000600 C5090982 sb 2
S 00000600 09090982 sb 3
S 00000600 09090909 sb 0
S 00000600 FF090909 sh 2
S 00000600 FF09FF09 sh 0
S 00000400 FF09FF09 lw after merges
S 00000FFC 0000000C finishing store
